/* rtl/hazard_pkg.sv */
// Shared types for the single-issue hazard detector
// Referenced by scoped name from every RTL module and the testbench

package hazard_pkg;

  // Integer register index, x0..x31
  typedef logic [4:0] reg_addr_t;

  // Execute stages tracked for forwarding decisions (EX1..EX3)
  localparam int dep_stages_lp = 3;

  // Decoded status of the instruction waiting at issue
  typedef struct packed {
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      irs1_v;
    logic      irs2_v;
    logic      iwb_v;
    // Execution pipe that produces the result
    logic      pipe_aux_v;
    logic      pipe_mul_v;
    logic      pipe_mem_early_v;
    logic      pipe_mem_final_v;
    // Result returns through a late writeback port
    logic      late_wb_v;
    logic      mem_v;
    logic      fence_v;
    logic      csr_v;
    logic      long_v;
  } isd_status_t;

  // Record of one in-flight instruction in an execute stage
  // Pipe flags are set only when that pipe writes an integer register
  typedef struct packed {
    logic      instr_v;
    logic      mem_v;
    logic      aux_wb_v;
    logic      mul_wb_v;
    logic      emem_wb_v;
    logic      fmem_wb_v;
    reg_addr_t rd_addr;
  } dep_status_t;

  // Index 0 is EX1
  typedef dep_status_t [dep_stages_lp-1:0] dep_stages_t;

  // Readiness and occupancy flags from the back-end units
  typedef struct packed {
    logic mem_ready;
    logic idiv_ready;
    logic ptw_busy;
    logic cmd_full;
    logic credits_full;
    logic credits_empty;
  } unit_status_t;

  // Completion of a multi-cycle integer result
  typedef struct packed {
    logic      v;
    reg_addr_t rd_addr;
  } late_wb_t;

endpackage

/* rtl/issue_gate.sv */
// Control and structural hazards, dispatch handshake and interrupt gating
// Ready never depends on isd_v_i, so the issue stage may wait on it freely

`timescale 1ns/1ns

module issue_gate
  (
    input  logic                     isd_v_i,
    input  hazard_pkg::isd_status_t  isd_status_i,
    input  hazard_pkg::unit_status_t units_i,
    input  hazard_pkg::dep_stages_t  dep_stages_i,
    input  logic                     data_haz_i,
    input  logic                     irq_pending_i,
    output logic                     dispatch_ready_o,
    output logic                     dispatch_fire_o,
    output logic                     interrupt_v_o
  );

  logic mem_in_pipe;
  logic any_in_pipe;
  logic fence_haz;
  logic credit_haz;
  logic serial_haz;
  logic control_haz;
  logic struct_haz;

  always_comb
  begin
    mem_in_pipe = 1'b0;
    any_in_pipe = 1'b0;
    for (int i = 0; i < hazard_pkg::dep_stages_lp; i++)
    begin
      mem_in_pipe = mem_in_pipe | dep_stages_i[i].mem_v;
      any_in_pipe = any_in_pipe | dep_stages_i[i].instr_v;
    end

    // Fence drains outstanding memory traffic first
    fence_haz   = isd_status_i.fence_v
                & (~units_i.credits_empty | mem_in_pipe | ~units_i.mem_ready);
    credit_haz  = isd_status_i.mem_v & units_i.credits_full;
    // CSR and long ops run alone in the execute stages
    serial_haz  = (isd_status_i.csr_v | isd_status_i.long_v) & any_in_pipe;
    control_haz = fence_haz | credit_haz | serial_haz;

    struct_haz  = units_i.ptw_busy
                | units_i.cmd_full
                | (isd_status_i.mem_v & ~units_i.mem_ready)
                | (isd_status_i.long_v & ~units_i.idiv_ready);
  end

  assign dispatch_ready_o = ~(control_haz | struct_haz | data_haz_i);
  assign dispatch_fire_o  = isd_v_i & dispatch_ready_o;

  // Interrupts are held off while the page-table walker is active
  assign interrupt_v_o = irq_pending_i & ~units_i.ptw_busy;

endmodule

/* rtl/dep_tracker.sv */
// Dependency records of dispatched instructions through EX1..EX3
// A cycle without a dispatch shifts an empty record into EX1

`timescale 1ns/1ns

module dep_tracker
  (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    dispatch_fire_i,
    input  hazard_pkg::isd_status_t isd_status_i,
    output hazard_pkg::dep_stages_t dep_stages_o
  );

  hazard_pkg::dep_status_t dep_next;
  hazard_pkg::dep_stages_t dep_stages_r;

  // Record of the dispatching instruction, pipe flags only for integer writes
  always_comb
  begin
    dep_next           = '0;
    if (dispatch_fire_i)
    begin
      dep_next.instr_v   = 1'b1;
      dep_next.mem_v     = isd_status_i.mem_v;
      dep_next.aux_wb_v  = isd_status_i.pipe_aux_v & isd_status_i.iwb_v;
      dep_next.mul_wb_v  = isd_status_i.pipe_mul_v & isd_status_i.iwb_v;
      dep_next.emem_wb_v = isd_status_i.pipe_mem_early_v & isd_status_i.iwb_v;
      dep_next.fmem_wb_v = isd_status_i.pipe_mem_final_v & isd_status_i.iwb_v;
      dep_next.rd_addr   = isd_status_i.rd_addr;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      dep_stages_r <= '0;
    end
    else
    begin
      dep_stages_r[0] <= dep_next;
      for (int i = 1; i < hazard_pkg::dep_stages_lp; i++)
      begin
        dep_stages_r[i] <= dep_stages_r[i-1];
      end
    end
  end

  assign dep_stages_o = dep_stages_r;

endmodule

/* rtl/late_wb_scoreboard.sv */
// Pending bits for integer registers awaiting a late writeback
// Marked on dispatch, cleared by late_wb_i; a mark on the same edge wins

`timescale 1ns/1ns

module late_wb_scoreboard
  (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    dispatch_fire_i,
    input  hazard_pkg::isd_status_t isd_status_i,
    input  hazard_pkg::late_wb_t    late_wb_i,
    output logic [1:0]              rs_pending_o,
    output logic                    rd_pending_o
  );

  localparam int num_regs_lp = 2 ** $bits(hazard_pkg::reg_addr_t);

  logic [num_regs_lp-1:0] pending_r;
  logic                   score_v;
  logic                   clear_v;

  // x0 is hardwired, so it is never marked
  assign score_v = dispatch_fire_i
                 & isd_status_i.late_wb_v
                 & isd_status_i.iwb_v
                 & (isd_status_i.rd_addr != '0);
  assign clear_v = late_wb_i.v;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      pending_r <= '0;
    end
    else
    begin
      if (clear_v)
      begin
        pending_r[late_wb_i.rd_addr] <= 1'b0;
      end
      // Later assignment gives the mark priority over the clear
      if (score_v)
      begin
        pending_r[isd_status_i.rd_addr] <= 1'b1;
      end
    end
  end

  // Lookups for the current issue status
  assign rs_pending_o[0] = pending_r[isd_status_i.rs1_addr];
  assign rs_pending_o[1] = pending_r[isd_status_i.rs2_addr];
  assign rd_pending_o    = pending_r[isd_status_i.rd_addr];

endmodule

/* rtl/data_hazard_check.sv */
// Read-after-write and write-after-write checks for the issuing instruction
// Combines per-stage forwarding limits with the late writeback scoreboard

`timescale 1ns/1ns

module data_hazard_check
  (
    input  hazard_pkg::isd_status_t isd_status_i,
    input  hazard_pkg::dep_stages_t dep_stages_i,
    input  logic [1:0]              rs_pending_i,
    input  logic                    rd_pending_i,
    output logic                    data_haz_o
  );

  logic rs1_haz;
  logic rs2_haz;
  logic rd_haz;

  // Whether a producer in stage idx still cannot forward its result
  function automatic logic stage_blocks(input int idx, input hazard_pkg::dep_status_t rec);
    case (idx)
      0:       return rec.aux_wb_v | rec.mul_wb_v | rec.emem_wb_v | rec.fmem_wb_v;
      1:       return rec.fmem_wb_v | rec.mul_wb_v;
      // EX3 results are all on the bypass network
      default: return 1'b0;
    endcase
  endfunction

  // Read of one source register against the stages and the scoreboard
  function automatic logic src_blocked(
    input hazard_pkg::reg_addr_t   addr,
    input logic                    read_v,
    input logic                    pending,
    input hazard_pkg::dep_stages_t stages
  );
    logic hit;
    hit = pending;
    for (int i = 0; i < hazard_pkg::dep_stages_lp; i++)
    begin
      hit = hit | ((stages[i].rd_addr == addr) & stage_blocks(i, stages[i]));
    end
    return read_v & (addr != '0) & hit;
  endfunction

  always_comb
  begin
    rs1_haz = src_blocked(isd_status_i.rs1_addr, isd_status_i.irs1_v,
                          rs_pending_i[0], dep_stages_i);
    rs2_haz = src_blocked(isd_status_i.rs2_addr, isd_status_i.irs2_v,
                          rs_pending_i[1], dep_stages_i);
    // Write-after-write against an outstanding late result
    rd_haz  = isd_status_i.iwb_v & rd_pending_i & (isd_status_i.rd_addr != '0);
  end

  assign data_haz_o = rs1_haz | rs2_haz | rd_haz;

endmodule

/* rtl/hazard_detector.sv */
// Top level of the hazard detector
// Decides each cycle whether the issuing instruction may dispatch, and gates interrupts

`timescale 1ns/1ns

module hazard_detector
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // Issue handshake
    input  logic                     isd_v_i,
    input  hazard_pkg::isd_status_t  isd_status_i,
    output logic                     dispatch_ready_o,

    // Back-end status
    input  hazard_pkg::unit_status_t units_i,
    input  hazard_pkg::late_wb_t     late_wb_i,

    input  logic                     irq_pending_i,
    output logic                     interrupt_v_o
  );

  logic                    dispatch_fire;
  hazard_pkg::dep_stages_t dep_stages;
  logic [1:0]              rs_pending;
  logic                    rd_pending;
  logic                    data_haz;

  issue_gate i_issue_gate
    (
      .isd_v_i          (isd_v_i),
      .isd_status_i     (isd_status_i),
      .units_i          (units_i),
      .dep_stages_i     (dep_stages),
      .data_haz_i       (data_haz),
      .irq_pending_i    (irq_pending_i),
      .dispatch_ready_o (dispatch_ready_o),
      .dispatch_fire_o  (dispatch_fire),
      .interrupt_v_o    (interrupt_v_o)
    );

  dep_tracker i_dep_tracker
    (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .dispatch_fire_i (dispatch_fire),
      .isd_status_i    (isd_status_i),
      .dep_stages_o    (dep_stages)
    );

  late_wb_scoreboard i_late_wb_scoreboard
    (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .dispatch_fire_i (dispatch_fire),
      .isd_status_i    (isd_status_i),
      .late_wb_i       (late_wb_i),
      .rs_pending_o    (rs_pending),
      .rd_pending_o    (rd_pending)
    );

  data_hazard_check i_data_hazard_check
    (
      .isd_status_i (isd_status_i),
      .dep_stages_i (dep_stages),
      .rs_pending_i (rs_pending),
      .rd_pending_i (rd_pending),
      .data_haz_o   (data_haz)
    );

endmodule

/* test/hazard_detector_asserts.sv */
// Concurrent checks on the issue handshake and the interrupt output
// Bound into the hazard detector top level

`timescale 1ns/1ns

module hazard_detector_asserts
  (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     isd_v_i,
    input hazard_pkg::isd_status_t  isd_status_i,
    input logic                     dispatch_ready_o,
    input hazard_pkg::unit_status_t units_i,
    input logic                     interrupt_v_o
  );

  // Walker activity holds interrupts off
  a_irq_walker_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    units_i.ptw_busy |-> !interrupt_v_o)
    else $error("interrupt_v_o high while the page-table walker is busy");

  a_no_fire_cmd_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    units_i.cmd_full |-> !(isd_v_i && dispatch_ready_o))
    else $error("dispatch fired while the command queue is full");

  // A stalled instruction is held until it dispatches
  a_held_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (isd_v_i && !dispatch_ready_o) |=> (isd_v_i && $stable(isd_status_i)))
    else $error("issue payload changed while waiting for ready");

endmodule

bind hazard_detector hazard_detector_asserts i_hazard_detector_asserts
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .isd_v_i          (isd_v_i),
    .isd_status_i     (isd_status_i),
    .dispatch_ready_o (dispatch_ready_o),
    .units_i          (units_i),
    .interrupt_v_o    (interrupt_v_o)
  );

/* test/tb_hazard_detector.sv */
// Directed testbench for the hazard detector
// Drives issue, unit, writeback and interrupt inputs on the falling edge and checks the outputs

`timescale 1ns/1ns

module tb_hazard_detector;

  localparam int clk_period_lp = 4;
  localparam int reset_cycles_lp = 8;
  // Cycles per test: reset, after reset, stage rules, scoreboard, control, structural
  localparam int budget_cycles_lp = reset_cycles_lp + 1 + 12 + 19 + 19 + 18 + 20;
  localparam int margin_cycles_lp = 50;

  logic                     clk;
  logic                     rst_n;
  logic                     isd_v;
  hazard_pkg::isd_status_t  isd_status;
  logic                     dispatch_ready;
  hazard_pkg::unit_status_t units;
  hazard_pkg::late_wb_t     late_wb;
  logic                     irq_pending;
  logic                     interrupt_v;

  int err_cnt;
  int check_cnt;

  hazard_detector i_dut
    (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .isd_v_i          (isd_v),
      .isd_status_i     (isd_status),
      .dispatch_ready_o (dispatch_ready),
      .units_i          (units),
      .late_wb_i        (late_wb),
      .irq_pending_i    (irq_pending),
      .interrupt_v_o    (interrupt_v)
    );

  initial
  begin
    clk = 1'b0;
  end

  always #(clk_period_lp / 2) clk = ~clk;

  // All units ready, no credits outstanding
  function automatic hazard_pkg::unit_status_t idle_units();
    hazard_pkg::unit_status_t u;
    u               = '0;
    u.mem_ready     = 1'b1;
    u.idiv_ready    = 1'b1;
    u.credits_empty = 1'b1;
    return u;
  endfunction

  function automatic hazard_pkg::isd_status_t alu_op(input hazard_pkg::reg_addr_t rs1,
                                                     input hazard_pkg::reg_addr_t rs2,
                                                     input hazard_pkg::reg_addr_t rd);
    hazard_pkg::isd_status_t s;
    s            = '0;
    s.rs1_addr   = rs1;
    s.rs2_addr   = rs2;
    s.rd_addr    = rd;
    s.irs1_v     = 1'b1;
    s.irs2_v     = 1'b1;
    s.iwb_v      = 1'b1;
    s.pipe_aux_v = 1'b1;
    return s;
  endfunction

  // Load whose data returns from the final memory stage
  function automatic hazard_pkg::isd_status_t load_op(input hazard_pkg::reg_addr_t rs1,
                                                      input hazard_pkg::reg_addr_t rd);
    hazard_pkg::isd_status_t s;
    s                  = '0;
    s.rs1_addr         = rs1;
    s.rd_addr          = rd;
    s.irs1_v           = 1'b1;
    s.iwb_v            = 1'b1;
    s.mem_v            = 1'b1;
    s.pipe_mem_final_v = 1'b1;
    return s;
  endfunction

  function automatic hazard_pkg::isd_status_t late_op(input hazard_pkg::reg_addr_t rs1,
                                                      input hazard_pkg::reg_addr_t rd);
    hazard_pkg::isd_status_t s;
    s           = '0;
    s.rs1_addr  = rs1;
    s.rd_addr   = rd;
    s.irs1_v    = 1'b1;
    s.iwb_v     = 1'b1;
    s.late_wb_v = 1'b1;
    return s;
  endfunction

  task automatic check_ready(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Applies all inputs at the falling edge, returns once outputs have settled
  task automatic drive_cycle(input logic v, input hazard_pkg::isd_status_t s,
                             input hazard_pkg::unit_status_t u,
                             input hazard_pkg::late_wb_t wb, input logic irq);
    @(negedge clk);
    isd_v       = v;
    isd_status  = s;
    units       = u;
    late_wb     = wb;
    irq_pending = irq;
    #1;
  endtask

  task automatic drive_issue(input logic v, input hazard_pkg::isd_status_t s);
    drive_cycle(v, s, units, late_wb, irq_pending);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_issue(1'b0, '0);
  endtask

  // Holds s at issue, expects ready low for n_low cycles and then high
  task automatic expect_stall(input hazard_pkg::isd_status_t s, input int n_low,
                              input string what);
    drive_issue(1'b1, s);
    for (int i = 0; i < n_low; i++)
    begin
      check_ready(dispatch_ready, 1'b0, what);
      drive_issue(1'b1, s);
    end
    check_ready(dispatch_ready, 1'b1, what);
  endtask

  task automatic test_after_reset();
    hazard_pkg::reg_addr_t rs1;
    hazard_pkg::reg_addr_t rs2;
    hazard_pkg::reg_addr_t rd;
    drive_issue(1'b0, '0);
    check_ready(dispatch_ready, 1'b1, "ready after reset");
    check_ready(interrupt_v, 1'b0, "interrupt after reset");
    // Sources in x1..x15 and destinations in x16..x31 never collide
    for (int n = 0; n < 8; n++)
    begin
      rs1 = hazard_pkg::reg_addr_t'($urandom_range(15, 1));
      rs2 = hazard_pkg::reg_addr_t'($urandom_range(15, 1));
      rd  = hazard_pkg::reg_addr_t'($urandom_range(31, 16));
      drive_issue(1'b1, alu_op(rs1, rs2, rd));
      check_ready(dispatch_ready, 1'b1, "independent instruction");
    end
    idle_cycles(3);
  endtask

  task automatic test_stage_rules();
    drive_issue(1'b1, load_op(5'd1, 5'd5));
    check_ready(dispatch_ready, 1'b1, "load of r5");
    expect_stall(alu_op(5'd5, 5'd2, 5'd20), 2, "reader of r5 behind final-mem load");
    idle_cycles(3);
    drive_issue(1'b1, alu_op(5'd3, 5'd4, 5'd6));
    check_ready(dispatch_ready, 1'b1, "aux producer of r6");
    expect_stall(alu_op(5'd1, 5'd6, 5'd21), 1, "reader of r6 behind aux producer");
    idle_cycles(3);
    drive_issue(1'b1, load_op(5'd1, 5'd0));
    check_ready(dispatch_ready, 1'b1, "load to x0");
    drive_issue(1'b1, alu_op(5'd0, 5'd0, 5'd22));
    check_ready(dispatch_ready, 1'b1, "reader of x0 behind EX1");
    drive_issue(1'b1, alu_op(5'd0, 5'd0, 5'd23));
    check_ready(dispatch_ready, 1'b1, "reader of x0 behind EX2");
    idle_cycles(3);
  endtask

  task automatic test_scoreboard();
    hazard_pkg::isd_status_t reader;
    hazard_pkg::isd_status_t writer;
    hazard_pkg::late_wb_t    wb;
    reader = alu_op(5'd7, 5'd1, 5'd24);
    writer = alu_op(5'd2, 5'd3, 5'd7);
    drive_issue(1'b1, late_op(5'd1, 5'd7));
    check_ready(dispatch_ready, 1'b1, "late producer of r7");
    // Valid stays low so the payload may alternate while r7 is pending
    for (int i = 0; i < 6; i++)
    begin
      drive_issue(1'b0, reader);
      check_ready(dispatch_ready, 1'b0, "reader of pending r7");
      drive_issue(1'b0, writer);
      check_ready(dispatch_ready, 1'b0, "writer of pending r7");
    end
    wb.v       = 1'b1;
    wb.rd_addr = 5'd7;
    drive_cycle(1'b0, reader, units, wb, 1'b0);
    check_ready(dispatch_ready, 1'b0, "reader of r7 before clearing edge");
    drive_cycle(1'b1, reader, units, '0, 1'b0);
    check_ready(dispatch_ready, 1'b1, "reader of r7 after clearing edge");
    drive_issue(1'b1, writer);
    check_ready(dispatch_ready, 1'b1, "writer of r7 after clear");
    idle_cycles(3);
  endtask

  task automatic test_control();
    hazard_pkg::isd_status_t  csr;
    hazard_pkg::isd_status_t  fence;
    hazard_pkg::isd_status_t  ld;
    hazard_pkg::unit_status_t u;
    csr         = alu_op(5'd3, 5'd0, 5'd26);
    csr.csr_v   = 1'b1;
    fence       = '0;
    fence.fence_v = 1'b1;
    ld          = load_op(5'd1, 5'd27);
    drive_issue(1'b1, alu_op(5'd1, 5'd2, 5'd25));
    check_ready(dispatch_ready, 1'b1, "instruction ahead of CSR");
    expect_stall(csr, 3, "CSR behind a dispatch");
    idle_cycles(3);
    u               = idle_units();
    u.credits_empty = 1'b0;
    drive_cycle(1'b1, fence, u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b0, "fence with credits outstanding");
    drive_cycle(1'b1, fence, u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b0, "fence with credits outstanding");
    u.credits_empty = 1'b1;
    u.mem_ready     = 1'b0;
    drive_cycle(1'b1, fence, u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b0, "fence with memory not ready");
    drive_cycle(1'b1, fence, idle_units(), '0, 1'b0);
    check_ready(dispatch_ready, 1'b1, "fence with memory drained");
    u              = idle_units();
    u.credits_full = 1'b1;
    drive_cycle(1'b1, ld, u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b0, "memory op with credits full");
    drive_cycle(1'b1, ld, u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b0, "memory op with credits full");
    drive_cycle(1'b1, ld, idle_units(), '0, 1'b0);
    check_ready(dispatch_ready, 1'b1, "memory op with credits free");
    idle_cycles(3);
  endtask

  task automatic test_structural();
    hazard_pkg::isd_status_t  s;
    hazard_pkg::isd_status_t  lng;
    hazard_pkg::unit_status_t u;
    s          = alu_op(5'd1, 5'd2, 5'd29);
    lng        = alu_op(5'd1, 5'd2, 5'd30);
    lng.long_v = 1'b1;
    u          = idle_units();
    u.ptw_busy = 1'b1;
    drive_cycle(1'b0, s, u, '0, 1'b1);
    check_ready(dispatch_ready, 1'b0, "ALU op with walker busy");
    check_ready(interrupt_v, 1'b0, "interrupt with walker busy");
    drive_cycle(1'b0, load_op(5'd1, 5'd28), u, '0, 1'b1);
    check_ready(dispatch_ready, 1'b0, "load with walker busy");
    drive_cycle(1'b0, s, idle_units(), '0, 1'b1);
    check_ready(interrupt_v, 1'b1, "interrupt with walker idle");
    drive_cycle(1'b0, s, idle_units(), '0, 1'b0);
    check_ready(interrupt_v, 1'b0, "interrupt with none pending");
    u          = idle_units();
    u.cmd_full = 1'b1;
    drive_cycle(1'b1, s, u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b0, "ALU op with command queue full");
    drive_cycle(1'b1, s, u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b0, "ALU op with command queue full");
    drive_cycle(1'b1, s, idle_units(), '0, 1'b0);
    check_ready(dispatch_ready, 1'b1, "ALU op with command queue free");
    idle_cycles(3);
    u            = idle_units();
    u.idiv_ready = 1'b0;
    drive_cycle(1'b0, lng, u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b0, "long op with divider busy");
    drive_cycle(1'b1, alu_op(5'd3, 5'd4, 5'd31), u, '0, 1'b0);
    check_ready(dispatch_ready, 1'b1, "ALU op with divider busy");
    drive_cycle(1'b0, '0, idle_units(), '0, 1'b0);
    idle_cycles(3);
    drive_issue(1'b1, lng);
    check_ready(dispatch_ready, 1'b1, "long op with divider ready");
    idle_cycles(3);
  endtask

  initial
  begin
    rst_n       = 1'b0;
    isd_v       = 1'b0;
    isd_status  = '0;
    units       = idle_units();
    late_wb     = '0;
    irq_pending = 1'b0;
    err_cnt     = 0;
    check_cnt   = 0;
    void'($urandom(86552));
    repeat (reset_cycles_lp) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_after_reset();
    test_stage_rules();
    test_scoreboard();
    test_control();
    test_structural();
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(clk_period_lp * (budget_cycles_lp + margin_cycles_lp));
    $display("Watchdog expired: the tests did not finish within %0d cycles",
             budget_cycles_lp + margin_cycles_lp);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* sources.f */
rtl/hazard_pkg.sv
rtl/issue_gate.sv
rtl/dep_tracker.sv
rtl/late_wb_scoreboard.sv
rtl/data_hazard_check.sv
rtl/hazard_detector.sv
test/hazard_detector_asserts.sv
test/tb_hazard_detector.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the hazard detector testbench with Verilator, runs it and scans the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_hazard_detector -f sources.f \
  && ./obj_dir/Vtb_hazard_detector 2>&1 | tee sim.log \
  || { echo "Verilator build or simulation run did not complete"; exit 1; }
grep -q "Test FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
exit 0
